/* emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

   // ##############################
   // Sizes and link IDs
   // ##############################
   localparam int PW = 104;                    // Packet width
   localparam int AW = 32;                     // Address width
   localparam int DW = 32;                     // Data width

   localparam logic [11:0] ELINK_ID = 12'h810; // Local link
   localparam logic [11:0] CHIP_ID  = 12'h808; // Remote chip

   // ##############################
   // Packet field positions
   // ##############################
   localparam int CTRL_LSB   = 0;
   localparam int CTRL_MSB   = 7;
   localparam int WRITE_BIT  = 0;              // Write flag inside CTRL

   localparam int DST_LSB    = 8;
   localparam int DST_MSB    = 39;
   localparam int CHIPID_LSB = 28;             // Chip ID in top of DSTADDR
   localparam int CHIPID_MSB = 39;

   localparam int DATA_LSB   = 40;
   localparam int DATA_MSB   = 71;

   localparam int SRC_LSB    = 72;
   localparam int SRC_MSB    = 103;

   // ##############################
   // Generator and memory
   // ##############################
   localparam int NUM_TRANS = 16;              // Transactions per phase

   localparam int MEM_WORDS = 64;
   localparam int MEM_AW    = 6;
   localparam int MEM_LSB   = DST_LSB + 2;     // DSTADDR bit 2
   localparam int MEM_MSB   = DST_LSB + 7;     // DSTADDR bit 7

   localparam logic [DW-1:0] DATA_BASE = 32'hA500_0000;

   // Generator sequencing
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ,
      DONE
   } egen_state_t;

   // Packet command matching the write flag
   typedef enum logic {
      CMD_READ  = 1'b0,
      CMD_WRITE = 1'b1
   } emesh_cmd_t;

endpackage

`default_nettype wire

/* egen_fsm.sv */
`default_nettype none

module egen_fsm (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  start,   // Kick off one write/read run
   input  logic                  last,    // Index at end of phase
   input  logic                  accept,  // Transfer on selected channel
   output emesh_pkg::emesh_cmd_t phase,   // Command of next packet to load
   output logic                  active,  // Generator has packets to load
   output logic                  done     // One-cycle end pulse
);

   import emesh_pkg::*;

   egen_state_t state;
   egen_state_t state_nxt;

   // ##############################
   // Next state
   // ##############################
   always_comb begin
      state_nxt = state;                                // Hold by default
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = WRITE;                       // Packer loads on this edge
            end
         end
         WRITE: begin
            if (accept && last) begin
               state_nxt = READ;                        // No gap into read phase
            end
         end
         READ: begin
            if (accept && last) begin
               state_nxt = DONE;
            end
         end
         DONE: begin
            state_nxt = IDLE;                           // Single cycle
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // ##############################
   // State register
   // ##############################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Outputs look one state ahead so the packer
   // registers the matching packet on the same edge
   always_comb begin
      active = (state_nxt == WRITE) || (state_nxt == READ);
      phase  = (state_nxt == READ) ? CMD_READ : CMD_WRITE;
   end

   assign done = (state == DONE);                       // Cycle after last read

endmodule

`default_nettype wire

/* egen_counter.sv */
`default_nettype none

module egen_counter (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       active,  // Low between runs
   input  logic       accept,  // Packet taken by the link
   output logic [3:0] index,   // Accepted count in this phase
   output logic       last     // Final packet of the phase
);

   import emesh_pkg::*;

   // ##############################
   // Transfer count
   // ##############################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         index <= '0;
      end else if (!active) begin
         index <= '0;                                   // Ready for next start
      end else if (accept) begin
         if (last) begin
            index <= '0;                                // Read phase restarts at zero
         end else begin
            index <= index + 4'd1;
         end
      end
   end

   assign last = (index == 4'(NUM_TRANS - 1));

endmodule

`default_nettype wire

/* egen_packer.sv */
`default_nettype none

module egen_packer (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       active,    // More packets to issue
   input  emesh_pkg::emesh_cmd_t      phase,     // Command of next packet
   input  logic [3:0]                 index,     // Index of packet on the bus
   input  logic                       wait_in,   // Selected channel wait
   output logic                       tx_access,
   output logic [emesh_pkg::PW-1:0]   tx_packet
);

   import emesh_pkg::*;

   logic          accepted;
   logic          load;
   logic [3:0]    load_index;
   logic [AW-1:0] dst_addr;
   logic [PW-1:0] packet_nxt;

   assign accepted = tx_access & ~wait_in;
   assign load     = active & (~tx_access | accepted);  // Empty or just taken

   // Counter still shows the packet being taken, so step past it
   always_comb begin
      if (!tx_access) begin
         load_index = index;                            // First packet of a run
      end else if (index == 4'(NUM_TRANS - 1)) begin
         load_index = 4'd0;                             // Phase boundary
      end else begin
         load_index = index + 4'd1;
      end
   end

   // ##############################
   // Packet fields
   // ##############################
   always_comb begin
      dst_addr   = {CHIP_ID, 14'b0, load_index, 2'b00}; // Word address
      packet_nxt = '0;
      packet_nxt[CTRL_MSB:CTRL_LSB] = {7'b0, phase};    // Bit 0 is write flag
      packet_nxt[DST_MSB:DST_LSB]   = dst_addr;
      if (phase == CMD_WRITE) begin
         packet_nxt[DATA_MSB:DATA_LSB] = DATA_BASE + DW'(load_index);
      end else begin
         // Return address for the response
         packet_nxt[SRC_MSB:SRC_LSB] = {ELINK_ID, 14'b0, load_index, 2'b00};
      end
   end

   // ##############################
   // Output register
   // ##############################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_access <= 1'b0;
      end else if (load) begin
         tx_access <= 1'b1;
      end else if (accepted) begin
         tx_access <= 1'b0;                             // Run finished
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         tx_packet <= packet_nxt;                       // Held while wait_in high
      end
   end

endmodule

`default_nettype wire

/* emem_port.sv */
`default_nettype none

module emem_port (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     rxwr_access,
   input  logic [emesh_pkg::PW-1:0] rxwr_packet,
   input  logic                     rxrd_access,
   input  logic [emesh_pkg::PW-1:0] rxrd_packet,
   input  logic                     mem_wait,     // Memory holds a response
   output logic                     rxrd_wait,
   output logic                     mem_access,
   output logic [emesh_pkg::PW-1:0] mem_packet
);

   import emesh_pkg::*;

   logic          wr_valid;
   logic          rd_id_ok;
   logic          rd_load;
   logic          rd_release;
   logic          rd_held;
   logic          rd_full;
   logic [PW-1:0] rd_buf;

   // Traffic for the local link is dropped here
   assign wr_valid = rxwr_access & (rxwr_packet[CHIPID_MSB:CHIPID_LSB] != ELINK_ID);
   assign rd_id_ok = (rxrd_packet[CHIPID_MSB:CHIPID_LSB] != ELINK_ID);

   // ##############################
   // Read buffer control
   // ##############################
   assign rd_release = rd_full & ~wr_valid & ~mem_wait; // Write wins the slot
   assign rd_held    = rd_full & ~rd_release;
   assign rxrd_wait  = wr_valid | rd_held;
   assign rd_load    = rxrd_access & ~rxrd_wait & rd_id_ok;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_full <= 1'b0;
      end else begin
         rd_full <= rd_load | rd_held;                  // Refill while draining
      end
   end

   always_ff @(posedge clk) begin
      if (rd_load) begin
         rd_buf <= rxrd_packet;
      end
   end

   // ##############################
   // Memory side
   // ##############################
   assign mem_access = wr_valid | rd_release;
   assign mem_packet = wr_valid ? rxwr_packet : rd_buf;

endmodule

`default_nettype wire

/* emem.sv */
`default_nettype none

module emem (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     mem_access,
   input  logic [emesh_pkg::PW-1:0] mem_packet,
   input  logic                     txrr_wait,    // Link stalls responses
   output logic                     mem_wait,     // Response stuck in register
   output logic                     txrr_access,
   output logic [emesh_pkg::PW-1:0] txrr_packet
);

   import emesh_pkg::*;

   logic [DW-1:0]     mem [MEM_WORDS];
   logic [MEM_AW-1:0] word;
   logic              wr_en;
   logic              rd_req;
   logic [PW-1:0]     resp_packet;

   // ##############################
   // Request decode
   // ##############################
   assign word   = mem_packet[MEM_MSB:MEM_LSB];                   // Word of DSTADDR
   assign wr_en  = mem_access & mem_packet[WRITE_BIT];
   assign rd_req = mem_access & ~mem_packet[WRITE_BIT];

   assign mem_wait = txrr_access & txrr_wait;

   // Writes land even while a response waits
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[word] <= mem_packet[DATA_MSB:DATA_LSB];
      end
   end

   // ##############################
   // Read response
   // ##############################
   always_comb begin
      resp_packet = '0;                                            // SRCADDR left zero
      resp_packet[CTRL_MSB:CTRL_LSB] = 8'h01;                      // Goes back as a write
      resp_packet[DST_MSB:DST_LSB]   = mem_packet[SRC_MSB:SRC_LSB];
      resp_packet[DATA_MSB:DATA_LSB] = mem[word];
   end

   // The port only releases a read when mem_wait is low,
   // so an idle or accepted register is free to reload
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         txrr_access <= 1'b0;
      end else if (!mem_wait) begin
         txrr_access <= rd_req;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req && !mem_wait) begin
         txrr_packet <= resp_packet;                               // Stable under wait
      end
   end

endmodule

`default_nettype wire

/* elink_example.sv */
`default_nettype none

module elink_example (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     start,        // Start generator
   output logic                     done,         // Generator finished
   // Remote write channel
   output logic                     txwr_access,
   output logic [emesh_pkg::PW-1:0] txwr_packet,
   input  logic                     txwr_wait,
   // Remote read channel
   output logic                     txrd_access,
   output logic [emesh_pkg::PW-1:0] txrd_packet,
   input  logic                     txrd_wait,
   // Incoming traffic
   input  logic                     rxwr_access,
   input  logic [emesh_pkg::PW-1:0] rxwr_packet,
   input  logic                     rxrd_access,
   input  logic [emesh_pkg::PW-1:0] rxrd_packet,
   output logic                     rxrd_wait,
   // Read responses
   output logic                     txrr_access,
   output logic [emesh_pkg::PW-1:0] txrr_packet,
   input  logic                     txrr_wait
);

   import emesh_pkg::*;

   emesh_cmd_t    phase;
   logic          active;
   logic          last;
   logic          accept;
   logic [3:0]    index;
   logic          tx_access;
   logic [PW-1:0] tx_packet;
   logic          tx_is_write;
   logic          tx_wait;
   logic          mem_access;
   logic [PW-1:0] mem_packet;
   logic          mem_wait;

   // ##############################
   // Transaction generator
   // ##############################
   egen_fsm egen_fsm (.clk(clk), .arst_n(arst_n), .start(start), .last(last),
                      .accept(accept), .phase(phase), .active(active), .done(done));

   egen_counter egen_counter (.clk(clk), .arst_n(arst_n), .active(active),
                              .accept(accept), .index(index), .last(last));

   egen_packer egen_packer (.clk(clk), .arst_n(arst_n), .active(active), .phase(phase),
                            .index(index), .wait_in(tx_wait), .tx_access(tx_access),
                            .tx_packet(tx_packet));

   // The held packet's command picks the channel, since phase already
   // points at the next packet when a phase ends
   assign tx_is_write = tx_packet[WRITE_BIT];
   assign tx_wait     = tx_is_write ? txwr_wait : txrd_wait;
   assign accept      = tx_access & ~tx_wait;

   assign txwr_access = tx_access & tx_is_write;
   assign txwr_packet = tx_packet;
   assign txrd_access = tx_access & ~tx_is_write;
   assign txrd_packet = tx_packet;

   // ##############################
   // Memory
   // ##############################
   emem_port emem_port (.clk(clk), .arst_n(arst_n),
                        .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet),
                        .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet),
                        .mem_wait(mem_wait), .rxrd_wait(rxrd_wait),
                        .mem_access(mem_access), .mem_packet(mem_packet));

   emem emem (.clk(clk), .arst_n(arst_n), .mem_access(mem_access),
              .mem_packet(mem_packet), .txrr_wait(txrr_wait), .mem_wait(mem_wait),
              .txrr_access(txrr_access), .txrr_packet(txrr_packet));

endmodule

`default_nettype wire

/* tb_elink_example.sv */
`default_nettype none

module tb_elink_example;

   timeunit 1ns;
   timeprecision 1ps;

   import emesh_pkg::*;

   logic          clk, arst_n, start, done;
   logic          txwr_access, txwr_wait, txrd_access, txrd_wait;
   logic          rxwr_access, rxrd_access, rxrd_wait, txrr_access, txrr_wait;
   logic [PW-1:0] txwr_packet, txrd_packet, rxwr_packet, rxrd_packet, txrr_packet;

   integer        seed = 87338;
   integer        cycle_cnt = 0;                   // Rising edges seen
   logic [DW-1:0] mem_model [MEM_WORDS];           // Scoreboard of memory words
   logic [PW-1:0] wr_q[$], rd_q[$], xfer_q[$], exp_q[$];
   integer        exp_cycle_q[$];                  // Cycle each read was taken

   elink_example UUT (.clk(clk), .arst_n(arst_n), .start(start), .done(done),
      .txwr_access(txwr_access), .txwr_packet(txwr_packet), .txwr_wait(txwr_wait),
      .txrd_access(txrd_access), .txrd_packet(txrd_packet), .txrd_wait(txrd_wait),
      .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet), .rxrd_access(rxrd_access),
      .rxrd_packet(rxrd_packet), .rxrd_wait(rxrd_wait), .txrr_access(txrr_access),
      .txrr_packet(txrr_packet), .txrr_wait(txrr_wait));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                      // 20 ns period
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic check_equal(input logic [PW-1:0] actual, input logic [PW-1:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Simulation FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out at %0t ns waiting for %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "Timeout");
   endtask

   // ##############################
   // Expected packets
   // ##############################
   function automatic logic [PW-1:0] gen_packet(input logic is_write, input integer idx);
      logic [PW-1:0] p;
      p        = '0;
      p[7:0]   = {7'b0, is_write};                 // Write flag
      p[39:8]  = {CHIP_ID, 14'b0, idx[3:0], 2'b00};
      if (is_write) begin
         p[71:40] = DATA_BASE + idx;
      end else begin
         p[103:72] = {ELINK_ID, 14'b0, idx[3:0], 2'b00};
      end
      return p;
   endfunction

   function automatic logic [PW-1:0] make_response(input logic [PW-1:0] rd);
      logic [PW-1:0] p;
      p        = '0;                               // SRCADDR stays zero
      p[7:0]   = 8'h01;
      p[39:8]  = rd[103:72];                       // Back to requester
      p[71:40] = mem_model[rd[15:10]];
      return p;
   endfunction

   // ##############################
   // Generator run with loop capture
   // ##############################
   task automatic run_generator(input bit random_wait);
      integer wr_cnt;
      integer rd_cnt;
      integer start_cycle;
      integer timeout;
      bit     held;
      wr_cnt  = 0;
      rd_cnt  = 0;
      timeout = 0;
      held    = 1'b0;
      wr_q.delete();
      rd_q.delete();
      @(negedge clk);
      start       = 1'b1;
      start_cycle = cycle_cnt;
      do begin
         @(negedge clk);
         start     = 1'b0;
         txwr_wait = random_wait ? 1'($random(seed)) : 1'b0;
         txrd_wait = random_wait ? 1'($random(seed)) : 1'b0;
         #1;
         check_equal(held & ~(txwr_access | txrd_access), 0, "access dropped under wait");
         if (txwr_access) begin                    // Held packet keeps its index
            check_equal(txrd_access, 0, "both channels active");
            check_equal(txwr_packet, gen_packet(1'b1, wr_cnt), "write packet");
         end
         if (txrd_access) begin
            check_equal(wr_cnt, NUM_TRANS, "read before write phase finished");
            check_equal(txrd_packet, gen_packet(1'b0, rd_cnt), "read packet");
         end
         held = (txwr_access & txwr_wait) | (txrd_access & txrd_wait);
         if (txwr_access && !txwr_wait) begin
            wr_q.push_back(txwr_packet);
            wr_cnt = wr_cnt + 1;
         end
         if (txrd_access && !txrd_wait) begin
            rd_q.push_back(txrd_packet);
            rd_cnt = rd_cnt + 1;
         end
         timeout = timeout + 1;
         if (timeout > 300) report_timeout("generator done");
      end while (!done);
      check_equal(wr_cnt, NUM_TRANS, "writes before done");
      check_equal(rd_cnt, NUM_TRANS, "reads before done");
      if (!random_wait) begin
         check_equal(cycle_cnt - start_cycle, 2 * NUM_TRANS + 1, "cycles start to done");
      end
      @(negedge clk);
      #1;
      check_equal(done, 0, "done longer than one cycle");
   endtask

   // Link side writes with no stall
   task automatic send_writes();
      logic [PW-1:0] pkt;
      foreach (xfer_q[i]) begin
         pkt = xfer_q[i];
         @(negedge clk);
         rxwr_access = 1'b1;
         rxwr_packet = pkt;
         if (pkt[39:28] != ELINK_ID) begin
            mem_model[pkt[15:10]] = pkt[71:40];    // Local ID is dropped
         end
      end
      @(negedge clk);
      rxwr_access = 1'b0;
   endtask

   // ##############################
   // Reads and response collection
   // ##############################
   task automatic run_reads(input bit stall);
      integer        next;
      integer        quiet;
      integer        timeout;
      integer        taken_cycle;
      bit            held;
      bit            saw_wait;
      logic [PW-1:0] held_pkt;
      next     = 0;
      quiet    = 0;
      timeout  = 0;
      held     = 1'b0;
      saw_wait = 1'b0;
      while (next < xfer_q.size() || exp_q.size() != 0 || quiet < 4) begin
         @(negedge clk);
         rxrd_access = (next < xfer_q.size());
         if (rxrd_access) rxrd_packet = xfer_q[next];
         txrr_wait = stall ? 1'($random(seed)) : 1'b0;
         #1;
         saw_wait = saw_wait | rxrd_wait;
         if (rxrd_access && !rxrd_wait) begin
            if (rxrd_packet[39:28] != ELINK_ID) begin
               exp_q.push_back(make_response(rxrd_packet));
               exp_cycle_q.push_back(cycle_cnt);
            end
            next = next + 1;
         end
         if (held) begin
            check_equal(txrr_access, 1, "response dropped under wait");
            check_equal(txrr_packet, held_pkt, "response changed under wait");
         end
         held     = txrr_access & txrr_wait;
         held_pkt = txrr_packet;
         if (txrr_access && !txrr_wait) begin
            check_equal(exp_q.size() != 0, 1, "response with no read outstanding");
            check_equal(txrr_packet, exp_q.pop_front(), "response packet");
            taken_cycle = exp_cycle_q.pop_front();
            if (!stall) check_equal(cycle_cnt - taken_cycle, 2, "response latency");
         end
         quiet   = txrr_access ? 0 : quiet + 1;
         timeout = timeout + 1;
         if (timeout > 400) report_timeout("read responses");
      end
      if (stall) check_equal(saw_wait, 1, "rxrd_wait raised by held response");
   endtask

   initial begin
      logic [PW-1:0] pkt;
      arst_n      = 1'b0;
      start       = 1'b0;
      txwr_wait   = 1'b0;
      txrd_wait   = 1'b0;
      rxwr_access = 1'b0;
      rxwr_packet = '0;
      rxrd_access = 1'b0;
      rxrd_packet = '0;
      txrr_wait   = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      #1;
      check_equal({txwr_access, txrd_access, txrr_access, rxrd_wait, done}, 0, "reset state");

      run_generator(1'b0);                         // Full rate with exact cycle count
      run_generator(1'b1);                         // Random waits on both channels

      xfer_q = wr_q;                               // Loop the captured packets back
      send_writes();
      xfer_q = rd_q;
      run_reads(1'b0);
      run_reads(1'b1);                             // Random txrr_wait

      // Local ID traffic must not reach memory
      pkt          = gen_packet(1'b1, 3);
      pkt[39:28]   = ELINK_ID;
      pkt[71:40]   = 32'h5A5A_0F0F;
      xfer_q.delete();
      xfer_q.push_back(pkt);
      send_writes();
      pkt          = gen_packet(1'b0, 5);
      pkt[39:28]   = ELINK_ID;
      xfer_q.delete();
      xfer_q.push_back(pkt);
      xfer_q.push_back(gen_packet(1'b0, 3));       // Word 3 still holds old data
      run_reads(1'b0);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* elink_example.f */
emesh_pkg.sv
egen_fsm.sv
egen_counter.sv
egen_packer.sv
emem_port.sv
emem.sv
elink_example.sv
tb_elink_example.sv

/* Bender.yml */
package:
  name: elink_example

sources:
  - emesh_pkg.sv
  - egen_fsm.sv
  - egen_counter.sv
  - egen_packer.sv
  - emem_port.sv
  - emem.sv
  - elink_example.sv
  - target: test
    files:
      - tb_elink_example.sv
